// File: flist.f
common/lsu_pkg.sv
rtl/lsu/lsu_writeback.sv
rtl/lsu/lsu.sv
rtl/axil_sram.sv
rtl/lsu_mem_top.sv
dv/tb_lsu_mem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_lsu_mem -Mdir obj_dir \
  -f flist.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_lsu_mem > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// File: dv/tb_lsu_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lsu_mem;

  localparam int TIMEOUT = 100;

  logic                 clk;
  logic                 rst;
  logic                 in_valid;
  lsu_pkg::exu_to_lsu_t in_req;
  logic                 out_ready;
  logic                 in_ready;
  logic                 out_valid;
  lsu_pkg::lsu_to_wbu_t out_rsp;
  logic                 busy;

  logic [31:0] lfsr;
  logic [31:0] model [lsu_pkg::MEM_WORDS];
  int          errors;
  int          checks;

  lsu_mem_top u_lsu_mem_top (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_rsp   (out_rsp),
    .busy      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #2000000;
    $display("Simulation stopped by the watchdog at %0t", $time);
    $display("Testbench failed");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus and model.
  // ~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      if (lfsr[0]) begin
        lfsr = (lfsr >> 1) ^ 32'hB4BC_D35C;
      end else begin
        lfsr = lfsr >> 1;
      end
      val = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic lsu_pkg::exu_to_lsu_t make_req(input lsu_pkg::mem_op_e op,
                                                    input lsu_pkg::mem_size_e size,
                                                    input logic sgn,
                                                    input lsu_pkg::wd_sel_e wsel,
                                                    input lsu_pkg::csr_wd_sel_e csel,
                                                    input logic [31:0] addr,
                                                    input logic [31:0] data);
    lsu_pkg::exu_to_lsu_t r;
    r = '0;
    r.pc             = 32'h0040_0000 | {16'h0, addr[15:2], 2'b00};
    r.pc_next        = r.pc + 32'd4;
    r.instruction    = 32'h0000_A083 ^ {data[19:0], 12'h0};
    r.alu_result     = addr;
    r.src2           = data;
    r.mem_op         = op;
    r.mem_size       = size;
    r.mem_signed     = sgn;
    r.wd_sel         = wsel;
    r.csr_wd_sel     = csel;
    r.rd             = addr[6:2];
    r.csr_rd         = data[1:0];
    r.reg_write_en   = (op != lsu_pkg::MEM_STORE);
    r.csreg_write_en = data[2];
    return r;
  endfunction

  // Fields that pass straight through, plus the computed ones.
  function automatic lsu_pkg::lsu_to_wbu_t expect_rsp(input lsu_pkg::exu_to_lsu_t r,
                                                      input logic [31:0] wd,
                                                      input logic [31:0] csr_wd,
                                                      input logic fault);
    lsu_pkg::lsu_to_wbu_t e;
    e.pc             = r.pc;
    e.pc_next        = r.pc_next;
    e.instruction    = r.instruction;
    e.wd             = wd;
    e.csr_wd         = csr_wd;
    e.rd             = r.rd;
    e.csr_rd         = r.csr_rd;
    e.reg_write_en   = r.reg_write_en;
    e.csreg_write_en = r.csreg_write_en;
    e.ecall          = r.ecall;
    e.mem_fault      = fault;
    return e;
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    return model[int'(addr[31:2])];
  endfunction

  function automatic void model_store(input logic [31:0] addr, input lsu_pkg::mem_size_e size,
                                      input logic [31:0] data);
    int idx;
    int off;
    idx = int'(addr[31:2]);
    off = int'(addr[1:0]);
    case (size)
      lsu_pkg::SIZE_BYTE: model[idx][8*off +: 8] = data[7:0];
      lsu_pkg::SIZE_HALF: model[idx][8*off +: 16] = data[15:0];
      default:            model[idx] = data;
    endcase
  endfunction

  function automatic logic [31:0] lane_value(input logic [31:0] word,
                                             input lsu_pkg::mem_size_e size,
                                             input int off, input logic sgn);
    logic [31:0] v;
    case (size)
      lsu_pkg::SIZE_BYTE: v = {{24{sgn & word[8*off+7]}}, word[8*off +: 8]};
      lsu_pkg::SIZE_HALF: v = {{16{sgn & word[8*off+15]}}, word[8*off +: 16]};
      default:            v = word;
    endcase
    return v;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // Checks.
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic check_rsp(input lsu_pkg::lsu_to_wbu_t got, input lsu_pkg::lsu_to_wbu_t exp,
                           input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Handshake helpers.
  // ~~~~~~~~~~~~~~~~~~~~
  // All helpers start and end on a falling edge.
  task automatic send_req(input lsu_pkg::exu_to_lsu_t r);
    int n;
    n = 0;
    while (!in_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!in_ready) begin
      errors++;
      $display("Timed out at %0t waiting for the LSU to accept an instruction", $time);
    end else begin
      in_req   = r;
      in_valid = 1'b1;
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  task automatic wait_result(output lsu_pkg::lsu_to_wbu_t got);
    int n;
    n = 0;
    while (!out_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    got = out_rsp;
    if (!out_valid) begin
      errors++;
      $display("Timed out at %0t waiting for out_valid", $time);
    end
  endtask

  task automatic take_result();
    out_ready = 1'b1;
    @(negedge clk);
    out_ready = 1'b0;
  endtask

  task automatic run_op(input lsu_pkg::exu_to_lsu_t r, output lsu_pkg::lsu_to_wbu_t got);
    send_req(r);
    wait_result(got);
    take_result();
  endtask

  task automatic store_and_check(input logic [31:0] addr, input lsu_pkg::mem_size_e size,
                                 input logic [31:0] data);
    lsu_pkg::exu_to_lsu_t r;
    lsu_pkg::lsu_to_wbu_t got;
    r = make_req(lsu_pkg::MEM_STORE, size, 1'b0, lsu_pkg::WD_ALU, lsu_pkg::CSR_WD_ALU,
                 addr, data);
    run_op(r, got);
    check_rsp(got, expect_rsp(r, addr, addr, 1'b0), $sformatf("store at %h", addr));
    model_store(addr, size, data);
  endtask

  task automatic load_and_check(input logic [31:0] addr, input lsu_pkg::mem_size_e size,
                                input logic sgn);
    lsu_pkg::exu_to_lsu_t r;
    lsu_pkg::lsu_to_wbu_t got;
    logic [31:0]          exp;
    r = make_req(lsu_pkg::MEM_LOAD, size, sgn, lsu_pkg::WD_LOAD, lsu_pkg::CSR_WD_ALU,
                 addr, rand_bits(32));
    run_op(r, got);
    exp = lane_value(model_word(addr), size, int'(addr[1:0]), sgn);
    check_word(got.wd, exp, $sformatf("load size %0d signed %b at %h", size, sgn, addr));
    check_bit(got.mem_fault, 1'b0, $sformatf("fault on load at %h", addr));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Tests.
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic reset_and_passthrough();
    int                   e0;
    lsu_pkg::exu_to_lsu_t r;
    lsu_pkg::lsu_to_wbu_t got;
    e0 = errors;
    check_bit(out_valid, 1'b0, "out_valid after reset");
    check_bit(busy, 1'b0, "busy after reset");
    check_bit(in_ready, 1'b1, "in_ready after reset");
    r = make_req(lsu_pkg::MEM_NONE, lsu_pkg::SIZE_WORD, 1'b0, lsu_pkg::WD_ALU,
                 lsu_pkg::CSR_WD_ALU, rand_bits(32), rand_bits(32));
    r.ecall = 1'b1;
    run_op(r, got);
    check_rsp(got, expect_rsp(r, r.alu_result, r.alu_result, 1'b0), "pass-through");
    $display("reset_and_passthrough: %0d errors", errors - e0);
  endtask

  task automatic word_roundtrip();
    int          e0;
    logic [31:0] addrs [6];
    e0 = errors;
    for (int i = 0; i < 6; i++) begin
      addrs[i] = rand_bits(10) << 2;
      store_and_check(addrs[i], lsu_pkg::SIZE_WORD, rand_bits(32));
    end
    for (int i = 0; i < 6; i++) begin
      load_and_check(addrs[i], lsu_pkg::SIZE_WORD, 1'b0);
    end
    $display("word_roundtrip: %0d errors", errors - e0);
  endtask

  task automatic check_all_lanes(input logic [31:0] base);
    for (int s = 0; s < 2; s++) begin
      for (int o = 0; o < 4; o++) begin
        load_and_check(base + 32'(o), lsu_pkg::SIZE_BYTE, s[0]);
      end
      load_and_check(base, lsu_pkg::SIZE_HALF, s[0]);
      load_and_check(base + 32'd2, lsu_pkg::SIZE_HALF, s[0]);
    end
    load_and_check(base, lsu_pkg::SIZE_WORD, 1'b0);
  endtask

  task automatic sub_word_lanes();
    int          e0;
    logic [31:0] base;
    e0   = errors;
    base = 32'h0000_0100;
    store_and_check(base, lsu_pkg::SIZE_WORD, 32'h80FF_7F01);
    check_all_lanes(base);
    for (int o = 0; o < 4; o++) begin
      store_and_check(base + 32'(o), lsu_pkg::SIZE_BYTE, rand_bits(32));
    end
    check_all_lanes(base);
    store_and_check(base, lsu_pkg::SIZE_HALF, rand_bits(32));
    store_and_check(base + 32'd2, lsu_pkg::SIZE_HALF, rand_bits(32));
    check_all_lanes(base);
    $display("sub_word_lanes: %0d errors", errors - e0);
  endtask

  task automatic select_case(input lsu_pkg::wd_sel_e wsel, input lsu_pkg::csr_wd_sel_e csel);
    lsu_pkg::exu_to_lsu_t r;
    lsu_pkg::lsu_to_wbu_t got;
    logic [31:0]          exp_wd;
    r = make_req(lsu_pkg::MEM_NONE, lsu_pkg::SIZE_WORD, 1'b0, wsel, csel,
                 rand_bits(32), rand_bits(32));
    r.pc = rand_bits(32);
    case (wsel)
      lsu_pkg::WD_PC4:  exp_wd = r.pc + 32'd4;
      lsu_pkg::WD_SRC2: exp_wd = r.src2;
      default:          exp_wd = r.alu_result;
    endcase
    run_op(r, got);
    check_word(got.wd, exp_wd, $sformatf("wd for wd_sel %0d", wsel));
    check_word(got.csr_wd, (csel == lsu_pkg::CSR_WD_PC) ? r.pc : r.alu_result,
               $sformatf("csr_wd for csr_wd_sel %0d", csel));
  endtask

  task automatic write_data_select();
    int e0;
    e0 = errors;
    select_case(lsu_pkg::WD_ALU, lsu_pkg::CSR_WD_ALU);
    select_case(lsu_pkg::WD_PC4, lsu_pkg::CSR_WD_PC);
    select_case(lsu_pkg::WD_SRC2, lsu_pkg::CSR_WD_ALU);
    select_case(lsu_pkg::WD_ALU, lsu_pkg::CSR_WD_PC);
    $display("write_data_select: %0d errors", errors - e0);
  endtask

  task automatic fault_path();
    int                   e0;
    logic [31:0]          addr;
    lsu_pkg::exu_to_lsu_t r;
    lsu_pkg::lsu_to_wbu_t got;
    e0 = errors;
    store_and_check(32'h0, lsu_pkg::SIZE_WORD, rand_bits(32));
    addr = 32'(lsu_pkg::MEM_BYTES);
    r = make_req(lsu_pkg::MEM_LOAD, lsu_pkg::SIZE_WORD, 1'b0, lsu_pkg::WD_LOAD,
                 lsu_pkg::CSR_WD_ALU, addr, 32'h0);
    run_op(r, got);
    check_rsp(got, expect_rsp(r, 32'h0, addr, 1'b1), "load beyond memory");
    // Low index bits alias word 0, so a lost write would show there.
    r = make_req(lsu_pkg::MEM_STORE, lsu_pkg::SIZE_WORD, 1'b0, lsu_pkg::WD_ALU,
                 lsu_pkg::CSR_WD_ALU, addr, ~model_word(32'h0));
    run_op(r, got);
    check_bit(got.mem_fault, 1'b1, "fault on store beyond memory");
    r.alu_result = 32'hFFFF_FFFC;
    r.mem_op     = lsu_pkg::MEM_LOAD;
    r.wd_sel     = lsu_pkg::WD_LOAD;
    run_op(r, got);
    check_bit(got.mem_fault, 1'b1, "fault on load at top of address space");
    check_word(got.wd, 32'h0, "wd on faulted load");
    load_and_check(32'h0, lsu_pkg::SIZE_WORD, 1'b0);
    $display("fault_path: %0d errors", errors - e0);
  endtask

  task automatic back_pressure();
    int                   e0;
    lsu_pkg::exu_to_lsu_t r;
    lsu_pkg::lsu_to_wbu_t held;
    lsu_pkg::lsu_to_wbu_t got;
    e0 = errors;
    r = make_req(lsu_pkg::MEM_LOAD, lsu_pkg::SIZE_WORD, 1'b0, lsu_pkg::WD_LOAD,
                 lsu_pkg::CSR_WD_PC, 32'h0000_0100, 32'h0);
    send_req(r);
    wait_result(held);
    check_rsp(held, expect_rsp(r, model_word(32'h100), r.pc, 1'b0), "held load result");
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      check_bit(out_valid, 1'b1, "out_valid while stalled");
      check_bit(in_ready, 1'b0, "in_ready while stalled");
      check_bit(busy, 1'b1, "busy while stalled");
      check_rsp(out_rsp, held, "out_rsp while stalled");
    end
    take_result();
    check_bit(out_valid, 1'b0, "out_valid after release");
    check_bit(in_ready, 1'b1, "in_ready after release");
    r = make_req(lsu_pkg::MEM_NONE, lsu_pkg::SIZE_WORD, 1'b0, lsu_pkg::WD_SRC2,
                 lsu_pkg::CSR_WD_ALU, rand_bits(32), rand_bits(32));
    run_op(r, got);
    check_rsp(got, expect_rsp(r, r.src2, r.alu_result, 1'b0), "instruction after release");
    $display("back_pressure: %0d errors", errors - e0);
  endtask

  initial begin
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_req    = '0;
    out_ready = 1'b0;
    lfsr      = 32'd92;
    errors    = 0;
    checks    = 0;
    for (int i = 0; i < int'(lsu_pkg::MEM_WORDS); i++) begin
      model[i] = '0;
    end
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    reset_and_passthrough();
    word_roundtrip();
    sub_word_lanes();
    write_data_select();
    fault_path();
    back_pressure();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/lsu_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_mem_top (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  in_valid,
  input  lsu_pkg::exu_to_lsu_t in_req,
  input  wire                  out_ready,
  output logic                 in_ready,
  output logic                 out_valid,
  output lsu_pkg::lsu_to_wbu_t out_rsp,
  output logic                 busy
);

  // Data memory bus.
  lsu_pkg::axil_req_t mem_req;
  lsu_pkg::axil_rsp_t mem_rsp;

  lsu u_lsu (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_ready (out_ready),
    .in_req    (in_req),
    .mem_rsp   (mem_rsp),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_rsp   (out_rsp),
    .mem_req   (mem_req),
    .busy      (busy)
  );

  axil_sram #(
    .DEPTH (lsu_pkg::MEM_WORDS)
  ) u_sram (
    .clk (clk),
    .rst (rst),
    .req (mem_req),
    .rsp (mem_rsp)
  );

endmodule

`default_nettype wire

// File: rtl/axil_sram.sv
`timescale 1ns/10ps
`default_nettype none

module axil_sram #(
  parameter int unsigned DEPTH = lsu_pkg::MEM_WORDS
) (
  input  wire                clk,
  input  wire                rst,
  input  lsu_pkg::axil_req_t req,
  output lsu_pkg::axil_rsp_t rsp
);

  localparam int unsigned IDX_W = $clog2(DEPTH);
  localparam logic [29:0] DEPTH_W = 30'(DEPTH);

  logic [31:0] mem [DEPTH];

  logic             arready;
  logic             rvalid;
  logic [31:0]      rdata;
  logic [1:0]       rresp;
  logic             awready;
  logic             bvalid;
  logic [1:0]       bresp;
  logic             rd_in_range;
  logic             wr_in_range;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  assign rd_in_range = (req.araddr[31:2] < DEPTH_W);
  assign wr_in_range = (req.awaddr[31:2] < DEPTH_W);
  assign rd_idx      = req.araddr[IDX_W+1:2];
  assign wr_idx      = req.awaddr[IDX_W+1:2];

  // ~~~~~~~~~~~~~~~~~~~~
  // Read channel.
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= req.arvalid && !arready && !rvalid;
      if (req.arvalid && arready) begin
        rvalid <= 1'b1;
      end else if (req.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req.arvalid && arready) begin
      rdata <= rd_in_range ? mem[rd_idx] : '0;
      rresp <= rd_in_range ? lsu_pkg::AXI_RESP_OKAY : lsu_pkg::AXI_RESP_SLVERR;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Write channels.
  // ~~~~~~~~~~~~~~~~~~~~
  // AW and W are taken in the same cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      awready <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= req.awvalid && req.wvalid && !awready && !bvalid;
      if (awready) begin
        bvalid <= 1'b1;
      end else if (req.bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awready) begin
      bresp <= wr_in_range ? lsu_pkg::AXI_RESP_OKAY : lsu_pkg::AXI_RESP_SLVERR;
      for (int b = 0; b < 4; b++) begin
        if (wr_in_range && req.wstrb[b]) begin
          mem[wr_idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  assign rsp.arready = arready;
  assign rsp.rdata   = rdata;
  assign rsp.rresp   = rresp;
  assign rsp.rvalid  = rvalid;
  assign rsp.awready = awready;
  assign rsp.wready  = awready;
  assign rsp.bresp   = bresp;
  assign rsp.bvalid  = bvalid;

endmodule

`default_nettype wire

// File: rtl/lsu/lsu.sv
`timescale 1ns/10ps
`default_nettype none

module lsu (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  in_valid,
  input  wire                  out_ready,
  input  lsu_pkg::exu_to_lsu_t in_req,
  input  lsu_pkg::axil_rsp_t   mem_rsp,
  output logic                 in_ready,
  output logic                 out_valid,
  output lsu_pkg::lsu_to_wbu_t out_rsp,
  output lsu_pkg::axil_req_t   mem_req,
  output logic                 busy
);

  typedef enum logic [2:0] {
    IDLE,
    RD_ADDR,
    RD_DATA,
    WR_REQ,
    WR_RESP,
    DONE
  } state_e;

  state_e               state;
  lsu_pkg::exu_to_lsu_t rec;
  logic [31:0]          load_word;
  logic                 fault;
  logic                 aw_done;
  logic                 w_done;
  logic [31:0]          wd;
  logic [31:0]          csr_wd;
  logic [3:0]           strb;

  logic in_fire;
  logic r_fire;
  logic b_fire;
  logic aw_fire;
  logic w_fire;
  logic aw_ok;
  logic w_ok;

  assign in_fire = in_valid && in_ready;
  assign r_fire  = mem_req.rready && mem_rsp.rvalid;
  assign b_fire  = mem_req.bready && mem_rsp.bvalid;
  assign aw_fire = mem_req.awvalid && mem_rsp.awready;
  assign w_fire  = mem_req.wvalid && mem_rsp.wready;
  assign aw_ok   = aw_done || aw_fire;
  assign w_ok    = w_done || w_fire;

  assign in_ready = (state == IDLE);
  assign busy     = (state != IDLE);

  // ~~~~~~~~~~~~~~~~~~~~
  // Control FSM.
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      out_valid <= 1'b0;
      aw_done   <= 1'b0;
      w_done    <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          aw_done <= 1'b0;
          w_done  <= 1'b0;
          if (in_valid) begin
            case (in_req.mem_op)
              lsu_pkg::MEM_LOAD:  state <= RD_ADDR;
              lsu_pkg::MEM_STORE: state <= WR_REQ;
              default:            state <= DONE;
            endcase
          end
        end
        RD_ADDR: if (mem_rsp.arready) state <= RD_DATA;
        RD_DATA: if (r_fire) state <= DONE;
        WR_REQ: begin
          // AW and W may complete in different cycles.
          if (aw_ok && w_ok) begin
            state <= WR_RESP;
          end
          aw_done <= aw_ok;
          w_done  <= w_ok;
        end
        WR_RESP: if (b_fire) state <= DONE;
        DONE: begin
          if (!out_valid) begin
            out_valid <= 1'b1;
          end else if (out_ready) begin
            out_valid <= 1'b0;
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Instruction record and response capture.
  always_ff @(posedge clk) begin
    if (in_fire) begin
      rec       <= in_req;
      load_word <= '0;
      fault     <= 1'b0;
    end
    if (r_fire) begin
      load_word <= mem_rsp.rdata;
      fault     <= (mem_rsp.rresp != lsu_pkg::AXI_RESP_OKAY);
    end
    if (b_fire) begin
      fault <= (mem_rsp.bresp != lsu_pkg::AXI_RESP_OKAY);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // AXI master side.
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (rec.mem_size)
      lsu_pkg::SIZE_BYTE: strb = 4'b0001 << rec.alu_result[1:0];
      lsu_pkg::SIZE_HALF: strb = 4'b0011 << {rec.alu_result[1], 1'b0};
      default:            strb = 4'b1111;
    endcase
  end

  assign mem_req.araddr  = rec.alu_result;
  assign mem_req.arvalid = (state == RD_ADDR);
  assign mem_req.rready  = (state == RD_DATA);
  assign mem_req.awaddr  = rec.alu_result;
  assign mem_req.awvalid = (state == WR_REQ) && !aw_done;
  assign mem_req.wvalid  = (state == WR_REQ) && !w_done;
  assign mem_req.wdata   = rec.src2 << {rec.alu_result[1:0], 3'b000};
  assign mem_req.wstrb   = strb;
  assign mem_req.bready  = (state == WR_RESP);

  lsu_writeback u_writeback (
    .rec       (rec),
    .load_word (load_word),
    .wd        (wd),
    .csr_wd    (csr_wd)
  );

  // Result to write-back.
  assign out_rsp.pc             = rec.pc;
  assign out_rsp.pc_next        = rec.pc_next;
  assign out_rsp.instruction    = rec.instruction;
  assign out_rsp.wd             = wd;
  assign out_rsp.csr_wd         = csr_wd;
  assign out_rsp.rd             = rec.rd;
  assign out_rsp.csr_rd         = rec.csr_rd;
  assign out_rsp.reg_write_en   = rec.reg_write_en;
  assign out_rsp.csreg_write_en = rec.csreg_write_en;
  assign out_rsp.ecall          = rec.ecall;
  assign out_rsp.mem_fault      = fault;

endmodule

`default_nettype wire

// File: rtl/lsu/lsu_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_writeback (
  input  lsu_pkg::exu_to_lsu_t rec,
  input  wire [31:0]           load_word,
  output logic [31:0]          wd,
  output logic [31:0]          csr_wd
);

  logic [31:0] shifted;
  logic [31:0] load_ext;

  // Bring the addressed lane down to bit 0.
  assign shifted = load_word >> {rec.alu_result[1:0], 3'b000};

  always_comb begin
    case (rec.mem_size)
      lsu_pkg::SIZE_BYTE: load_ext = {{24{rec.mem_signed & shifted[7]}}, shifted[7:0]};
      lsu_pkg::SIZE_HALF: load_ext = {{16{rec.mem_signed & shifted[15]}}, shifted[15:0]};
      default:            load_ext = shifted;
    endcase
  end

  always_comb begin
    case (rec.wd_sel)
      lsu_pkg::WD_LOAD: wd = load_ext;
      lsu_pkg::WD_PC4:  wd = rec.pc + 32'd4;
      lsu_pkg::WD_SRC2: wd = rec.src2;
      default:          wd = rec.alu_result;
    endcase
  end

  always_comb begin
    case (rec.csr_wd_sel)
      lsu_pkg::CSR_WD_PC: csr_wd = rec.pc;
      default:            csr_wd = rec.alu_result;
    endcase
  end

endmodule

`default_nettype wire

// File: common/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Memory geometry.
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned MEM_WORDS = 1024;
  localparam int unsigned MEM_BYTES = MEM_WORDS * 4;

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_e;

  typedef enum logic [1:0] {
    WD_ALU  = 2'd0,
    WD_LOAD = 2'd1,
    WD_PC4  = 2'd2,
    WD_SRC2 = 2'd3
  } wd_sel_e;

  typedef enum logic {
    CSR_WD_ALU = 1'b0,
    CSR_WD_PC  = 1'b1
  } csr_wd_sel_e;

  // ~~~~~~~~~~~~~~~~~~~~
  // Stage records.
  // ~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] instruction;
    // Doubles as the memory address.
    logic [31:0] alu_result;
    // Doubles as the store data.
    logic [31:0] src2;
    mem_op_e     mem_op;
    mem_size_e   mem_size;
    logic        mem_signed;
    wd_sel_e     wd_sel;
    csr_wd_sel_e csr_wd_sel;
    logic [4:0]  rd;
    logic [1:0]  csr_rd;
    logic        reg_write_en;
    logic        csreg_write_en;
    logic        ecall;
  } exu_to_lsu_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] instruction;
    logic [31:0] wd;
    logic [31:0] csr_wd;
    logic [4:0]  rd;
    logic [1:0]  csr_rd;
    logic        reg_write_en;
    logic        csreg_write_en;
    logic        ecall;
    logic        mem_fault;
  } lsu_to_wbu_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // AXI4-Lite channels.
  // ~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [31:0] araddr;
    logic        arvalid;
    logic [31:0] awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        rready;
    logic        bready;
  } axil_req_t;

  typedef struct packed {
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
  } axil_rsp_t;

endpackage

`default_nettype wire
